// File: project.f
+incdir+verilog
+incdir+tb
verilog/video_pkg.sv
verilog/video_timing_if.sv
verilog/video_timer.sv
verilog/video_tilemap.sv
verilog/video_colmix.sv
verilog/video_top.sv
tb/video_tb.sv

// File: run_sim.sh
#!/bin/bash
# Build the video testbench with Verilator, run it, and look for the pass line.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module video_tb \
    -f project.f -o video_sim || { echo "Verilator build failed"; exit 1; }

sim_out=$(./obj_dir/video_sim)
echo "$sim_out"
echo "$sim_out" | grep -q "^TEST RESULT: PASS$" && exit 0 || exit 1

// File: tb/video_ref.svh
// Reference model for the video testbench, included inside the testbench
// module. Needs the model arrays vram_m, col_m and pal_m and the driven
// flip and gfx_en signals to be declared before the include.

// 16-bit Fibonacci LFSR with taps 16 14 13 11, stepped once per bit taken
function automatic logic [31:0] lfsr_draw(inout logic [15:0] st, input int nbits);
    logic        fb;
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < nbits; i++) begin
        fb  = st[15] ^ st[13] ^ st[12] ^ st[10];
        st  = {st[14:0], fb};
        val = {val[30:0], fb};
    end
    return val;
endfunction

// Tile ROM contents as a mix of the full address
function automatic video_pkg::tile_row_t ref_rom_row(input video_pkg::tile_rom_addr_t a);
    logic [31:0] mix;
    mix = {a[3:0], a, a, a[3:0]};
    return mix ^ (32'(a) * 32'h9E37_79B1);
endfunction

// Expected colour of screen pixel (x, y) packed as red, green and blue
function automatic logic [11:0] ref_pixel(input int x, input int y);
    int                  mx;
    int                  my;
    int                  idx;
    logic [7:0]          attr;
    logic [8:0]          code;
    video_pkg::tile_row_t row;
    video_pkg::pal_idx_t nib;
    video_pkg::pal_idx_t c;
    logic [7:0]          rg;
    logic [7:0]          b;
    mx   = flip ? 255 - x : x;
    my   = flip ? 223 - y : y;
    idx  = (my / 8) * 32 + mx / 8;
    attr = vram_m[1024 + idx];
    code = {attr[0], vram_m[idx]};
    row  = ref_rom_row({code, 3'(my % 8)});
    nib  = row[(mx % 8) * 4 +: 4];
    c    = gfx_en ? pal_m[{attr[7:4], nib}] : 4'd0;
    rg   = col_m[{c, 1'b0}];
    b    = col_m[{c, 1'b1}];
    return {rg[7:4], rg[3:0], b[3:0]};
endfunction

// File: tb/video_tb.sv
// Testbench for video_top. Checks raster timing, CPU access to VRAM and
// whole frames of pixels against a reference model of the tilemap path.
// A responder plays the tile ROM with random latency.
`include "video_defines.svh"

module video_tb;
    timeunit 1ns;
    timeprecision 100ps;

    logic                      clk;
    logic                      rst_n;
    logic                      pxl_cen;
    logic                      cen_cnt;
    logic                      flip;
    video_pkg::vram_addr_t     cpu_addr;
    logic [7:0]                cpu_dout;
    logic                      cpu_rnw;
    logic                      vram_cs;
    logic [7:0]                vram_dout;
    video_pkg::prom_addr_t     prog_addr;
    logic [7:0]                prog_data;
    logic                      prom_en;
    video_pkg::tile_rom_addr_t scr_addr;
    video_pkg::tile_row_t      scr_data;
    logic                      scr_ok;
    logic                      gfx_en;
    logic                      hs;
    logic                      vs;
    logic                      lhbl;
    logic                      lvbl;
    video_pkg::col_chan_t      red;
    video_pkg::col_chan_t      green;
    video_pkg::col_chan_t      blue;

    // Testbench copies of the memories
    logic [7:0]                vram_m [2048];
    logic [7:0]                col_m [32];
    logic [3:0]                pal_m [256];

    logic [15:0]               stim_lfsr;
    logic [15:0]               rom_lfsr;
    video_pkg::tile_rom_addr_t rom_last;
    int                        rom_wait;

    int                        errors;
    int                        checks;
    int                        shown;
    int                        tests_run;
    int                        tests_failed;
    string                     cmp_name;
    bit                        cmp_on;
    int                        pix_cnt;
    logic [11:0]               exp_px;

    `include "video_ref.svh"

    video_top dut (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .pxl_cen   ( pxl_cen   ),
        .flip      ( flip      ),
        .cpu_addr  ( cpu_addr  ),
        .cpu_dout  ( cpu_dout  ),
        .cpu_rnw   ( cpu_rnw   ),
        .vram_cs   ( vram_cs   ),
        .vram_dout ( vram_dout ),
        .prog_addr ( prog_addr ),
        .prog_data ( prog_data ),
        .prom_en   ( prom_en   ),
        .scr_addr  ( scr_addr  ),
        .scr_data  ( scr_data  ),
        .scr_ok    ( scr_ok    ),
        .gfx_en    ( gfx_en    ),
        .hs        ( hs        ),
        .vs        ( vs        ),
        .lhbl      ( lhbl      ),
        .lvbl      ( lvbl      ),
        .red       ( red       ),
        .green     ( green     ),
        .blue      ( blue      )
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        #1;
        cen_cnt = cen_cnt + 1'b1;
        pxl_cen = cen_cnt;              // Every second clock
    end

    // Tile ROM that picks a new latency for each new address
    always @(posedge clk) begin
        logic [31:0] v;
        #1;
        if (scr_addr !== rom_last) begin
            rom_last = scr_addr;
            v        = lfsr_draw(rom_lfsr, 3);
            rom_wait = int'(v % `ROM_MAX_LAT);     // 1 to 6 clocks
            scr_ok   = 1'b0;
        end else if (rom_wait > 0) begin
            rom_wait--;
        end
        if (rom_wait == 0 && !scr_ok) begin
            scr_data = ref_rom_row(rom_last);
            scr_ok   = 1'b1;
        end
    end

    task automatic check_count(input string name, input video_pkg::hcnt_t exp,
                               input video_pkg::hcnt_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            shown++;
            if (shown <= 20)
                $display("** Error %s: expected %0d, got %0d", name, exp, act);
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            shown++;
            if (shown <= 20)
                $display("** Error %s: expected 0x%h, got 0x%h", name, exp, act);
        end
    endtask

    task automatic check_color(input string name,
                               input video_pkg::col_chan_t er, input video_pkg::col_chan_t eg,
                               input video_pkg::col_chan_t eb, input video_pkg::col_chan_t ar,
                               input video_pkg::col_chan_t ag, input video_pkg::col_chan_t ab);
        checks++;
        if ({er, eg, eb} !== {ar, ag, ab}) begin
            errors++;
            shown++;
            if (shown <= 20)
                $display("** Error %s pixel %0d: expected rgb %h%h%h, got %h%h%h",
                         name, pix_cnt, er, eg, eb, ar, ag, ab);
        end
    endtask

    // Compares each visible pixel while a frame is armed
    always @(negedge clk) begin
        if (cmp_on && pxl_cen && lhbl && lvbl) begin
            exp_px = ref_pixel(pix_cnt % 256, pix_cnt / 256);
            check_color(cmp_name, exp_px[11:8], exp_px[7:4], exp_px[3:0], red, green, blue);
            pix_cnt++;
            if (pix_cnt == `H_VISIBLE * `V_VISIBLE)
                cmp_on = 1'b0;
        end
    end

    task automatic stop_on_timeout(input string what);
        $display("Timeout while waiting for %s", what);
        $display("TEST RESULT: FAIL");
        $finish;
    endtask

    task automatic report(input string name, input int err0);
        tests_run++;
        if (errors == err0) begin
            $display("%-20s ok", name);
        end else begin
            tests_failed++;
            $display("%-20s failed, %0d errors", name, errors - err0);
        end
    endtask

    task automatic wait_cen();
        int n;
        n = 0;
        @(negedge clk);
        while (!pxl_cen) begin
            n++;
            if (n > 4)
                stop_on_timeout("pixel enable");
            @(negedge clk);
        end
    endtask

    task automatic wait_vs_rise();
        int   n;
        logic prev;
        logic seen;
        n    = 0;
        prev = vs;
        seen = 1'b0;
        while (!seen) begin
            wait_cen();
            seen = vs && !prev;
            prev = vs;
            n++;
            if (n > 2 * `H_TOTAL * `V_TOTAL)
                stop_on_timeout("vertical sync");
        end
    endtask

    task automatic bus_idle();
        @(posedge clk);
        #1;
        vram_cs = 1'b0;
        cpu_rnw = 1'b1;
        prom_en = 1'b0;
    endtask

    task automatic vram_write(input video_pkg::vram_addr_t a, input logic [7:0] d);
        @(posedge clk);
        #1;
        vram_cs  = 1'b1;
        cpu_rnw  = 1'b0;
        cpu_addr = a;
        cpu_dout = d;
        vram_m[a] = d;
    endtask

    task automatic prom_write(input video_pkg::prom_addr_t a, input logic [7:0] d);
        @(posedge clk);
        #1;
        prom_en   = 1'b1;
        prog_addr = a;
        prog_data = d;
    endtask

    task automatic vram_read_check(input video_pkg::vram_addr_t a);
        @(posedge clk);
        #1;
        vram_cs  = 1'b1;
        cpu_rnw  = 1'b1;
        cpu_addr = a;
        @(posedge clk);
        #1;
        vram_cs = 1'b0;
        @(negedge clk);
        check_byte("vram readback", vram_m[a], vram_dout);
    endtask

    task automatic measure_raster();
        int   err0;
        int   n;
        int   len;
        int   vis_px;
        int   lines;
        int   vis_lines;
        logic prev_hs;
        logic prev_vs;
        logic started;
        logic done;
        err0 = errors;
        wait_vs_rise();
        {n, len, vis_px, lines, vis_lines} = '0;
        {prev_hs, prev_vs, started, done} = {hs, vs, 1'b0, 1'b0};
        while (!done) begin
            wait_cen();
            len++;
            if (lhbl)
                vis_px++;
            if (hs && !prev_hs) begin
                if (started) begin
                    check_count("line length", video_pkg::hcnt_t'(`H_TOTAL),
                                video_pkg::hcnt_t'(len));
                    check_count("visible pixels", video_pkg::hcnt_t'(`H_VISIBLE),
                                video_pkg::hcnt_t'(vis_px));
                end
                started = 1'b1;
                len     = 0;
                vis_px  = 0;
                lines++;
                if (lvbl)
                    vis_lines++;
            end
            done    = vs && !prev_vs;
            prev_hs = hs;
            prev_vs = vs;
            n++;
            if (n > `H_TOTAL * `V_TOTAL + 16)
                stop_on_timeout("end of frame");
        end
        check_count("frame lines", video_pkg::hcnt_t'(`V_TOTAL), video_pkg::hcnt_t'(lines));
        check_count("visible lines", video_pkg::hcnt_t'(`V_VISIBLE),
                    video_pkg::hcnt_t'(vis_lines));
        report("raster timing", err0);
    endtask

    task automatic exercise_vram();
        int                    err0;
        logic [31:0]           v;
        video_pkg::vram_addr_t addrs [32];
        err0 = errors;
        for (int i = 0; i < 32; i++) begin
            v        = lfsr_draw(stim_lfsr, 10);
            addrs[i] = {i[0], v[9:0]};      // Codes and attributes alternate
            v        = lfsr_draw(stim_lfsr, 8);
            vram_write(addrs[i], v[7:0]);
        end
        bus_idle();
        for (int i = 0; i < 32; i++)
            vram_read_check(addrs[i]);
        report("vram access", err0);
    endtask

    task automatic load_image();
        logic [31:0] v;
        for (int i = 0; i < 2048; i++) begin
            v = lfsr_draw(stim_lfsr, 8);
            vram_write(11'(i), v[7:0]);
        end
        for (int i = 0; i < 32; i++) begin
            v = lfsr_draw(stim_lfsr, 8);
            prom_write(10'(i), v[7:0]);
            col_m[i] = v[7:0];
        end
        for (int i = 0; i < 256; i++) begin
            v = lfsr_draw(stim_lfsr, 8);
            prom_write(10'(i + 32), v[7:0]);
            pal_m[i] = v[3:0];
        end
        bus_idle();
    endtask

    task automatic set_mode(input logic f, input logic g);
        @(posedge clk);
        #1;
        flip   = f;
        gfx_en = g;
    endtask

    task automatic run_frame(input string name);
        int err0;
        int n;
        err0     = errors;
        wait_vs_rise();
        cmp_name = name;
        pix_cnt  = 0;
        cmp_on   = 1'b1;
        n        = 0;
        while (cmp_on) begin
            @(negedge clk);
            n++;
            if (n > 4 * `H_TOTAL * `V_TOTAL)
                stop_on_timeout("a full visible frame");
        end
        report(name, err0);
    endtask

    initial begin
        logic [31:0] a;
        logic [31:0] d;
        {clk, rst_n, pxl_cen, cen_cnt, flip} = '0;
        cpu_addr  = '0;
        cpu_dout  = '0;
        cpu_rnw   = 1'b1;
        vram_cs   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        prom_en   = 1'b0;
        gfx_en    = 1'b1;
        scr_data  = '0;
        scr_ok    = 1'b0;
        stim_lfsr = 16'd36;
        rom_lfsr  = 16'd36;
        rom_last  = '1;
        rom_wait  = 0;
        {errors, checks, shown, tests_run, tests_failed, pix_cnt} = '0;
        cmp_on    = 1'b0;

        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        measure_raster();
        exercise_vram();
        load_image();
        run_frame("normal image");
        set_mode(1'b1, 1'b1);
        run_frame("flipped image");
        set_mode(1'b0, 1'b0);
        run_frame("layer disabled");
        set_mode(1'b0, 1'b1);

        // Nothing past the palette PROM may land anywhere
        for (int i = 0; i < 24; i++) begin
            a = lfsr_draw(stim_lfsr, 16);
            d = lfsr_draw(stim_lfsr, 8);
            prom_write(10'h120 + 10'(a[15:0] % 736), d[7:0]);
        end
        bus_idle();
        run_frame("download decoding");

        $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0 && tests_failed == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// File: verilog/video_top.sv
// Top of the video subsystem: raster timer, tilemap layer and mixer.
// PROM bytes arrive on one download port; the address picks the PROM.
// Tile graphics come from an external ROM that answers with scr_ok.
`include "video_defines.svh"

module video_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        pxl_cen,

    input  logic                        flip,

    // CPU interface
    input  video_pkg::vram_addr_t       cpu_addr,
    input  logic [7:0]                  cpu_dout,
    input  logic                        cpu_rnw,
    input  logic                        vram_cs,
    output logic [7:0]                  vram_dout,

    // PROM download
    input  video_pkg::prom_addr_t       prog_addr,
    input  logic [7:0]                  prog_data,
    input  logic                        prom_en,

    // Tile ROM
    output video_pkg::tile_rom_addr_t   scr_addr,
    input  video_pkg::tile_row_t        scr_data,
    input  logic                        scr_ok,

    input  logic                        gfx_en,

    output logic                        hs,
    output logic                        vs,
    output logic                        lhbl,
    output logic                        lvbl,
    output video_pkg::col_chan_t        red,
    output video_pkg::col_chan_t        green,
    output video_pkg::col_chan_t        blue
);

    video_timing_if      vt ();
    video_pkg::pal_idx_t scr_pxl;
    logic                col_prog_en;
    logic                pal_prog_en;
    logic [4:0]          col_offset;
    logic [7:0]          pal_offset;

    assign col_offset = 5'(prog_addr - video_pkg::prom_addr_t'(`COLPROM_BASE));
    assign pal_offset = 8'(prog_addr - video_pkg::prom_addr_t'(`PALPROM_BASE));

    // Each PROM decodes its own address range
    assign col_prog_en = prom_en &&                         // Final colours
                         prog_addr < video_pkg::prom_addr_t'(`COLPROM_BASE + `COLPROM_SIZE);
    assign pal_prog_en = prom_en &&                         // Tile palette
                         prog_addr >= video_pkg::prom_addr_t'(`PALPROM_BASE) &&
                         prog_addr <  video_pkg::prom_addr_t'(`PALPROM_BASE + `PALPROM_SIZE);

    assign hs = vt.hs;
    assign vs = vt.vs;

    video_timer u_timer (
        .clk      ( clk       ),
        .rst_n    ( rst_n     ),
        .pxl_cen  ( pxl_cen   ),
        .vt       ( vt.timer  )
    );

    video_tilemap u_tilemap (
        .clk       ( clk            ),
        .rst_n     ( rst_n          ),
        .pxl_cen   ( pxl_cen        ),
        .flip      ( flip           ),
        .vt        ( vt.layer       ),
        .cpu_addr  ( cpu_addr       ),
        .cpu_dout  ( cpu_dout       ),
        .cpu_rnw   ( cpu_rnw        ),
        .vram_cs   ( vram_cs        ),
        .vram_dout ( vram_dout      ),
        .prog_addr ( pal_offset     ),
        .prog_data ( prog_data[3:0] ),
        .prog_en   ( pal_prog_en    ),
        .scr_addr  ( scr_addr       ),
        .scr_data  ( scr_data       ),
        .scr_ok    ( scr_ok         ),
        .pix       ( scr_pxl        )
    );

    video_colmix u_colmix (
        .clk       ( clk         ),
        .rst_n     ( rst_n       ),
        .pxl_cen   ( pxl_cen     ),
        .pix       ( scr_pxl     ),
        .gfx_en    ( gfx_en      ),
        .pre_lhbl  ( vt.pre_lhbl ),
        .pre_lvbl  ( vt.pre_lvbl ),
        .prog_addr ( col_offset  ),
        .prog_data ( prog_data   ),
        .prog_en   ( col_prog_en ),
        .lhbl      ( lhbl        ),
        .lvbl      ( lvbl        ),
        .red       ( red         ),
        .green     ( green       ),
        .blue      ( blue        )
    );

    // One download byte lands in one PROM at most
    a_one_prom: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(col_prog_en && pal_prog_en)
    );

endmodule

// File: verilog/video_colmix.sv
// Colour mixer. Takes the layer colour index, looks it up in the final
// colour PROM and registers the channels on the pixel enable.
// Blanking is delayed to line up with the pixel path and the
// channels are held at zero outside the visible area.
`include "video_defines.svh"

module video_colmix (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 pxl_cen,

    input  video_pkg::pal_idx_t  pix,
    input  logic                 gfx_en,
    input  logic                 pre_lhbl,
    input  logic                 pre_lvbl,

    // Colour PROM download
    input  logic [4:0]           prog_addr,
    input  logic [7:0]           prog_data,
    input  logic                 prog_en,

    output logic                 lhbl,
    output logic                 lvbl,
    output video_pkg::col_chan_t red,
    output video_pkg::col_chan_t green,
    output video_pkg::col_chan_t blue
);

    logic [7:0]            col_prom [32];
    video_pkg::pal_idx_t   col_idx;
    logic [7:0]            rg_byte;
    logic [7:0]            b_byte;
    logic [`BLANK_DLY-1:0] lhbl_dly;
    logic [`BLANK_DLY-1:0] lvbl_dly;
    logic                  vis_next;

    assign col_idx = gfx_en ? pix : '0;     // Disabled layer shows colour 0

    always_ff @(posedge clk) begin
        if (prog_en)
            col_prom[prog_addr] <= prog_data;
    end

    // Two bytes per colour
    assign rg_byte = col_prom[{col_idx, 1'b0}];
    assign b_byte  = col_prom[{col_idx, 1'b1}];

    // Blanking as seen by the stage that loads the channels
    assign vis_next = lhbl_dly[`BLANK_DLY-2] & lvbl_dly[`BLANK_DLY-2];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lhbl_dly <= '0;
            lvbl_dly <= '0;
            red      <= '0;
            green    <= '0;
            blue     <= '0;
        end else if (pxl_cen) begin
            lhbl_dly <= {lhbl_dly[`BLANK_DLY-2:0], pre_lhbl};
            lvbl_dly <= {lvbl_dly[`BLANK_DLY-2:0], pre_lvbl};
            red      <= vis_next ? rg_byte[7:4] : '0;
            green    <= vis_next ? rg_byte[3:0] : '0;
            blue     <= vis_next ? b_byte[3:0]  : '0;
        end
    end

    assign lhbl = lhbl_dly[`BLANK_DLY-1];
    assign lvbl = lvbl_dly[`BLANK_DLY-1];

endmodule

// File: verilog/video_tilemap.sv
// Single tilemap layer. VRAM is shared with the CPU; the video port
// reads the tile code and attribute, then the row comes from the tile ROM.
// The fetch for the next tile starts at the fourth pixel of the current
// one and the row enters the shifter at the tile boundary.
// Pixels leave through the palette PROM one enable after their hdump.
`include "video_defines.svh"

module video_tilemap (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        pxl_cen,
    input  logic                        flip,

    video_timing_if.layer               vt,

    // CPU port
    input  video_pkg::vram_addr_t       cpu_addr,
    input  logic [7:0]                  cpu_dout,
    input  logic                        cpu_rnw,
    input  logic                        vram_cs,
    output logic [7:0]                  vram_dout,

    // Palette PROM download
    input  logic [7:0]                  prog_addr,
    input  video_pkg::pal_idx_t         prog_data,
    input  logic                        prog_en,

    // Tile ROM
    output video_pkg::tile_rom_addr_t   scr_addr,
    input  video_pkg::tile_row_t        scr_data,
    input  logic                        scr_ok,

    output video_pkg::pal_idx_t         pix
);

    logic [7:0]                vram [2048];
    logic [3:0]                pal_prom [256];

    video_pkg::fetch_state_e   state;
    video_pkg::vram_addr_t     vid_addr;
    logic [7:0]                vid_q;       // Video port read data
    logic                      line_end;
    logic [5:0]                fetch_col;
    video_pkg::vcnt_t          fetch_v;
    logic [4:0]                map_col;
    logic [7:0]                map_y;
    logic                      fetch_go;
    logic                      rom_take;
    logic                      tile_end;

    logic [9:0]                tile_idx;
    logic [2:0]                tile_row;
    logic                      flip_fetch;
    logic [7:0]                code_lo;
    logic [3:0]                pal_fetch;

    video_pkg::tile_row_t      row_buf;     // Waiting for the boundary
    logic [3:0]                pal_buf;
    logic                      flip_buf;
    video_pkg::tile_row_t      row_sh;
    logic [3:0]                pal_sh;
    logic                      flip_sh;
    video_pkg::pal_idx_t       sh_nib;

    // Next tile position; the last tile of a line wraps to the next line
    assign line_end  = vt.hdump >= video_pkg::hcnt_t'(`H_TOTAL - 8);
    assign fetch_col = line_end ? 6'd0 : vt.hdump[8:3] + 6'd1;
    assign fetch_v   = !line_end ? vt.vdump :
                       vt.vdump == video_pkg::vcnt_t'(`V_TOTAL - 1) ? '0 : vt.vdump + 9'd1;

    assign map_col = flip ? ~fetch_col[4:0] : fetch_col[4:0];
    assign map_y   = flip ? 8'(`V_VISIBLE - 1) - fetch_v[7:0] : fetch_v[7:0];

    assign fetch_go = state == video_pkg::FETCH_IDLE && vt.hdump[2:0] == 3'd3;
    assign rom_take = (state == video_pkg::FETCH_ROM || state == video_pkg::FETCH_WAIT)
                      && scr_ok;
    assign tile_end = vt.hdump[2:0] == 3'd7;

    // Code address while idle, attribute once the fetch has begun
    assign vid_addr = state == video_pkg::FETCH_IDLE ? {1'b0, map_y[7:3], map_col}
                                                     : {1'b1, tile_idx};

    always_ff @(posedge clk) begin
        if (vram_cs && !cpu_rnw)
            vram[cpu_addr] <= cpu_dout;
        vid_q <= vram[vid_addr];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            vram_dout <= '0;
        else if (vram_cs && cpu_rnw)
            vram_dout <= vram[cpu_addr];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= video_pkg::FETCH_IDLE;
            scr_addr <= '0;
        end else begin
            case (state)
                video_pkg::FETCH_IDLE: if (fetch_go) state <= video_pkg::FETCH_CODE;
                video_pkg::FETCH_CODE: state <= video_pkg::FETCH_ATTR;
                video_pkg::FETCH_ATTR: begin
                    scr_addr <= {vid_q[0], code_lo, tile_row};   // vid_q has the attribute
                    state    <= video_pkg::FETCH_ROM;
                end
                video_pkg::FETCH_ROM,
                video_pkg::FETCH_WAIT: state <= scr_ok ? video_pkg::FETCH_IDLE
                                                       : video_pkg::FETCH_WAIT;
                default: state <= video_pkg::FETCH_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_go) begin
            tile_idx   <= {map_y[7:3], map_col};
            tile_row   <= map_y[2:0];
            flip_fetch <= flip;
        end
        if (state == video_pkg::FETCH_CODE)
            code_lo <= vid_q;
        if (state == video_pkg::FETCH_ATTR)
            pal_fetch <= vid_q[7:4];
        if (rom_take) begin
            row_buf  <= scr_data;
            pal_buf  <= pal_fetch;
            flip_buf <= flip_fetch;
        end
    end

    // Flipped tiles leave from the top nibble
    assign sh_nib = flip_sh ? row_sh[31:28] : row_sh[3:0];

    always_ff @(posedge clk) begin
        if (prog_en)
            pal_prom[prog_addr] <= prog_data;
    end

    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            if (tile_end) begin
                row_sh  <= row_buf;
                pal_sh  <= pal_buf;
                flip_sh <= flip_buf;
            end else begin
                row_sh <= flip_sh ? row_sh << 4 : row_sh >> 4;
            end
            pix <= pal_prom[{pal_sh, sh_nib}];
        end
    end

    // A slow ROM must still finish before the row is needed
    a_fetch_done: assert property (
        @(posedge clk) disable iff (!rst_n)
        (pxl_cen && tile_end) |-> state == video_pkg::FETCH_IDLE
    );

endmodule

// File: verilog/video_timer.sv
// Raster timer. Counts pixel enables along a line and lines along a
// frame, and decodes sync and the undelayed blanking signals.
// Blanking here is raw; the mixer delays it to match the pixel path.
`include "video_defines.svh"

module video_timer (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              pxl_cen,

    video_timing_if.timer     vt
);

    video_pkg::hcnt_t hcnt;
    video_pkg::vcnt_t vcnt;
    logic             line_end;
    logic             frame_end;

    assign line_end  = hcnt == video_pkg::hcnt_t'(`H_TOTAL - 1);
    assign frame_end = vcnt == video_pkg::vcnt_t'(`V_TOTAL - 1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hcnt <= '0;
            vcnt <= '0;
        end else if (pxl_cen) begin
            if (line_end) begin
                hcnt <= '0;
                vcnt <= frame_end ? '0 : vcnt + 9'd1;   // Next line
            end else begin
                hcnt <= hcnt + 9'd1;
            end
        end
    end

    assign vt.hdump = hcnt;
    assign vt.vdump = vcnt;

    // Visible area starts at counter zero
    assign vt.pre_lhbl = hcnt < video_pkg::hcnt_t'(`H_VISIBLE);
    assign vt.pre_lvbl = vcnt < video_pkg::vcnt_t'(`V_VISIBLE);

    // Sync pulses sit inside blanking
    assign vt.hs = hcnt >= video_pkg::hcnt_t'(`HS_START) &&
                   hcnt <  video_pkg::hcnt_t'(`HS_START + `HS_LEN);
    assign vt.vs = vcnt >= video_pkg::vcnt_t'(`VS_START) &&
                   vcnt <  video_pkg::vcnt_t'(`VS_START + `VS_LEN);

    // The layer fetch relies on whole tiles per line
    a_hcnt_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        hcnt < video_pkg::hcnt_t'(`H_TOTAL)
    );

endmodule

// File: verilog/video_timing_if.sv
// Raster position and raw timing, from the timer to the layers.
// The timer drives everything; a layer only reads.
interface video_timing_if;

    video_pkg::hcnt_t hdump;
    video_pkg::vcnt_t vdump;
    logic             pre_lhbl;     // Undelayed horizontal blanking
    logic             pre_lvbl;
    logic             hs;
    logic             vs;

    modport timer (
        output hdump, vdump, pre_lhbl, pre_lvbl, hs, vs
    );

    modport layer (
        input  hdump, vdump, pre_lhbl, pre_lvbl, hs, vs
    );

endinterface

// File: verilog/video_pkg.sv
// Shared types of the video subsystem.
// Every width that means something has a name here.
// Modules refer to these types with scoped names.
package video_pkg;

    typedef logic [8:0]  hcnt_t;            // Horizontal position
    typedef logic [8:0]  vcnt_t;            // Line number
    typedef logic [10:0] vram_addr_t;       // Codes low, attributes high

    // 9-bit tile code followed by the 3-bit pixel row
    typedef logic [11:0] tile_rom_addr_t;

    // Eight 4-bit pixels with pixel n in nibble n
    typedef logic [31:0] tile_row_t;

    typedef logic [3:0]  pal_idx_t;
    typedef logic [3:0]  col_chan_t;
    typedef logic [9:0]  prom_addr_t;       // Download port address

    // Tile fetch sequence run once per 8 pixels
    typedef enum logic [2:0] {
        FETCH_IDLE,
        FETCH_CODE,
        FETCH_ATTR,
        FETCH_ROM,
        FETCH_WAIT
    } fetch_state_e;

endpackage

// File: verilog/video_defines.svh
// Fixed raster geometry, PROM download map and pipeline constants.
// Included by every RTL file that needs a size or a position.
`ifndef VIDEO_DEFINES_SVH
`define VIDEO_DEFINES_SVH

// Horizontal raster in pixel enables
`define H_TOTAL     384
`define H_VISIBLE   256
`define HS_START    288
`define HS_LEN      32

// Vertical raster in lines
`define V_TOTAL     264
`define V_VISIBLE   224
`define VS_START    240
`define VS_LEN      8

// Download address map
`define COLPROM_BASE  10'h000
`define COLPROM_SIZE  32
`define PALPROM_BASE  10'h020
`define PALPROM_SIZE  256

// Palette stage in the tilemap plus the mixer register
`define BLANK_DLY   2

`define ROM_MAX_LAT 6   // Worst tile ROM wait in clocks

`endif
